/* Bender.yml */
package:
  name: fpu_issue

export_include_dirs:
  - include

sources:
  - hw/fpu_pkg.sv
  - hw/fpu_decode.sv
  - hw/fpu_regfile.sv
  - hw/fpu_forward.sv
  - hw/fpu_exec.sv
  - hw/fpu_csr.sv
  - hw/fpu_issue_top.sv
  - target: test
    files:
      - tests/fpu_checker.sv
      - tests/fpu_tb.sv

/* flist.f */
+incdir+include
hw/fpu_pkg.sv
hw/fpu_decode.sv
hw/fpu_regfile.sv
hw/fpu_forward.sv
hw/fpu_exec.sv
hw/fpu_csr.sv
hw/fpu_issue_top.sv
tests/fpu_checker.sv
tests/fpu_tb.sv

/* hw/fpu_csr.sv */
`timescale 1ns/1ps

module fpu_csr (
  input  logic                clock,
  input  logic                reset,
  input  fpu_pkg::csr_req_t   req_i,
  input  logic [4:0]          accrue_i,
  input  logic                accrue_en_i,
  output fpu_pkg::csr_resp_t  resp_o
);

  logic [2:0] frm;
  logic [4:0] fflags;

  always_comb begin
    resp_o = '0;
    if (req_i.rden) begin
      resp_o.hit = 1'b1;
      case (req_i.addr)
        fpu_pkg::CSR_FFLAGS: resp_o.rdata[4:0] = fflags;
        fpu_pkg::CSR_FRM:    resp_o.rdata[2:0] = frm;
        fpu_pkg::CSR_FCSR:   resp_o.rdata[7:0] = {frm, fflags};
        default:             resp_o.hit = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      frm    <= '0;
      fflags <= '0;
    end else begin
      if (accrue_en_i) begin
        fflags <= fflags | accrue_i;
      end
      // Software write overrides accrual.
      if (req_i.wren) begin
        case (req_i.addr)
          fpu_pkg::CSR_FFLAGS: fflags <= req_i.wdata[4:0];
          fpu_pkg::CSR_FRM:    frm <= req_i.wdata[2:0];
          fpu_pkg::CSR_FCSR: begin
            fflags <= req_i.wdata[4:0];
            frm    <= req_i.wdata[7:5];
          end
          default: ;
        endcase
      end
    end
  end

endmodule

/* hw/fpu_decode.sv */
`timescale 1ns/1ps

module fpu_decode (
  input  logic [31:0]       instr_i,
  output fpu_pkg::fpu_dec_t dec_o
);

  fpu_pkg::opcode_e opcode;
  fpu_pkg::funct5_e funct5;
  logic [2:0]       funct3;
  logic [1:0]       fmt;
  logic             illegal;

  always_comb begin
    opcode  = fpu_pkg::opcode_e'(instr_i[6:0]);
    funct5  = fpu_pkg::funct5_e'(instr_i[31:27]);
    funct3  = instr_i[14:12];
    fmt     = instr_i[26:25];
    illegal = 1'b0;

    dec_o     = '0;
    dec_o.op  = fpu_pkg::OP_NONE;
    dec_o.rd  = instr_i[11:7];
    dec_o.rs1 = instr_i[19:15];
    dec_o.rs2 = instr_i[24:20];
    dec_o.rs3 = instr_i[31:27];

    case (opcode)
      fpu_pkg::OP_FP: begin
        if (fmt != 2'b00) begin
          illegal = 1'b1; // Only the S format.
        end
        case (funct5)
          fpu_pkg::F_SGNJ: begin
            dec_o.frden1 = 1'b1;
            dec_o.frden2 = 1'b1;
            dec_o.fwren  = 1'b1;
            case (funct3)
              3'd0: dec_o.op = fpu_pkg::OP_SGNJ;
              3'd1: dec_o.op = fpu_pkg::OP_SGNJN;
              3'd2: dec_o.op = fpu_pkg::OP_SGNJX;
              default: illegal = 1'b1;
            endcase
          end
          fpu_pkg::F_MINMAX: begin
            dec_o.frden1 = 1'b1;
            dec_o.frden2 = 1'b1;
            dec_o.fwren  = 1'b1;
            case (funct3)
              3'd0: dec_o.op = fpu_pkg::OP_MIN;
              3'd1: dec_o.op = fpu_pkg::OP_MAX;
              default: illegal = 1'b1;
            endcase
          end
          fpu_pkg::F_CMP: begin
            dec_o.frden1 = 1'b1;
            dec_o.frden2 = 1'b1;
            dec_o.xwren  = 1'b1;
            case (funct3)
              3'd2: dec_o.op = fpu_pkg::OP_FEQ;
              3'd1: dec_o.op = fpu_pkg::OP_FLT;
              3'd0: dec_o.op = fpu_pkg::OP_FLE;
              default: illegal = 1'b1;
            endcase
          end
          fpu_pkg::F_MV_X: begin
            dec_o.frden1 = 1'b1;
            dec_o.xwren  = 1'b1;
            case (funct3)
              3'd0: dec_o.op = fpu_pkg::OP_MV_X;
              3'd1: dec_o.op = fpu_pkg::OP_CLASS;
              default: illegal = 1'b1;
            endcase
          end
          fpu_pkg::F_MV_W: begin
            dec_o.fwren = 1'b1; // Source is the integer operand.
            dec_o.op    = fpu_pkg::OP_MV_W;
            if (funct3 != 3'd0) begin
              illegal = 1'b1;
            end
          end
          fpu_pkg::F_ADD, fpu_pkg::F_SUB, fpu_pkg::F_MUL, fpu_pkg::F_DIV,
          fpu_pkg::F_SQRT, fpu_pkg::F_CVT_W_S, fpu_pkg::F_CVT_S_W: illegal = 1'b1;
          default: illegal = 1'b1;
        endcase
      end
      fpu_pkg::OP_FLOAD, fpu_pkg::OP_FSTORE: illegal = 1'b1;
      fpu_pkg::OP_FMADD, fpu_pkg::OP_FMSUB,
      fpu_pkg::OP_FNMSUB, fpu_pkg::OP_FNMADD: illegal = 1'b1;
      default: illegal = 1'b1;
    endcase

    // No side effects for anything unsupported.
    if (illegal) begin
      dec_o.op     = fpu_pkg::OP_NONE;
      dec_o.frden1 = 1'b0;
      dec_o.frden2 = 1'b0;
      dec_o.fwren  = 1'b0;
      dec_o.xwren  = 1'b0;
    end
    dec_o.illegal = illegal;
  end

endmodule

/* hw/fpu_exec.sv */
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu_exec (
  input  fpu_pkg::fpu_dec_t     dec_i,
  input  fpu_pkg::fpu_rf_data_t opnd_i,
  input  logic [`FPU_XLEN-1:0]  xopnd_i,
  output fpu_pkg::fpu_resp_t    resp_o
);

  localparam logic [`FPU_FLEN-1:0] canonical_nan = 32'h7FC0_0000;

  logic [`FPU_FLEN-1:0] a, b;
  logic [9:0]           cls_a, cls_b;
  logic                 a_nan, b_nan, any_snan, any_nan, both_zero;
  logic                 lt_total, flt, feq, invalid;

  // One-hot RISC-V class, bit 0 is negative infinity.
  function automatic logic [9:0] classify(input logic [`FPU_FLEN-1:0] x);
    logic       exp_ones, exp_zero, man_zero;
    logic [9:0] cls;
    exp_ones = &x[30:23];
    exp_zero = ~|x[30:23];
    man_zero = ~|x[22:0];
    cls      = '0;
    if (exp_ones && !man_zero) cls[x[22] ? 9 : 8] = 1'b1;
    else if (exp_ones) cls[x[31] ? 0 : 7] = 1'b1;
    else if (exp_zero && man_zero) cls[x[31] ? 3 : 4] = 1'b1;
    else if (exp_zero) cls[x[31] ? 2 : 5] = 1'b1;
    else cls[x[31] ? 1 : 6] = 1'b1;
    return cls;
  endfunction

  always_comb begin
    a         = opnd_i.data1;
    b         = opnd_i.data2;
    cls_a     = classify(a);
    cls_b     = classify(b);
    a_nan     = cls_a[8] | cls_a[9];
    b_nan     = cls_b[8] | cls_b[9];
    any_nan   = a_nan | b_nan;
    any_snan  = cls_a[8] | cls_b[8];
    both_zero = (cls_a[3] | cls_a[4]) & (cls_b[3] | cls_b[4]);

    // Ordering with -0 below +0.
    if (a[31] != b[31]) lt_total = a[31];
    else if (a[31]) lt_total = a[30:0] > b[30:0];
    else lt_total = a[30:0] < b[30:0];

    flt     = !any_nan && lt_total && !both_zero;
    feq     = !any_nan && (a == b || both_zero);
    invalid = 1'b0;

    resp_o         = '0;
    resp_o.illegal = dec_i.illegal;
    resp_o.xwren   = dec_i.xwren;
    resp_o.fwren   = dec_i.fwren;
    resp_o.rd      = dec_i.rd;

    case (dec_i.op)
      fpu_pkg::OP_SGNJ:  resp_o.result = {b[31], a[30:0]};
      fpu_pkg::OP_SGNJN: resp_o.result = {~b[31], a[30:0]};
      fpu_pkg::OP_SGNJX: resp_o.result = {a[31] ^ b[31], a[30:0]};
      fpu_pkg::OP_MIN, fpu_pkg::OP_MAX: begin
        invalid = any_snan;
        if (a_nan && b_nan) resp_o.result = canonical_nan;
        else if (a_nan) resp_o.result = b;
        else if (b_nan) resp_o.result = a;
        else if (dec_i.op == fpu_pkg::OP_MIN) resp_o.result = lt_total ? a : b;
        else resp_o.result = lt_total ? b : a;
      end
      fpu_pkg::OP_FEQ: begin
        invalid       = any_snan; // Quiet compare.
        resp_o.result = {{(`FPU_FLEN-1){1'b0}}, feq};
      end
      fpu_pkg::OP_FLT: begin
        invalid       = any_nan;
        resp_o.result = {{(`FPU_FLEN-1){1'b0}}, flt};
      end
      fpu_pkg::OP_FLE: begin
        invalid       = any_nan;
        resp_o.result = {{(`FPU_FLEN-1){1'b0}}, flt | feq};
      end
      fpu_pkg::OP_CLASS: resp_o.result = {{(`FPU_FLEN-10){1'b0}}, cls_a};
      fpu_pkg::OP_MV_X:  resp_o.result = a;
      fpu_pkg::OP_MV_W:  resp_o.result = xopnd_i;
      default:           resp_o.result = '0;
    endcase

    resp_o.fflags = {invalid, 4'b0000}; // NV only.
  end

endmodule

/* hw/fpu_forward.sv */
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu_forward (
  input  fpu_pkg::fpu_dec_t     dec_i,
  input  fpu_pkg::fpu_rf_data_t rf_i,
  input  fpu_pkg::fpu_wb_t      ex_i,
  output fpu_pkg::fpu_rf_data_t opnd_o
);

  function automatic logic [`FPU_FLEN-1:0] select_opnd(
    input logic                    en,
    input logic [`FPU_RADDR_W-1:0] addr,
    input logic [`FPU_FLEN-1:0]    rf_data,
    input fpu_pkg::fpu_wb_t        ex
  );
    logic [`FPU_FLEN-1:0] opnd;
    opnd = '0;
    if (en) begin
      opnd = rf_data;
      if (ex.wren && ex.waddr == addr) begin
        opnd = ex.wdata; // Not yet written back.
      end
    end
    return opnd;
  endfunction

  assign opnd_o.data1 = select_opnd(dec_i.frden1, dec_i.rs1, rf_i.data1, ex_i);
  assign opnd_o.data2 = select_opnd(dec_i.frden2, dec_i.rs2, rf_i.data2, ex_i);
  assign opnd_o.data3 = select_opnd(dec_i.frden3, dec_i.rs3, rf_i.data3, ex_i);

endmodule

/* hw/fpu_issue_top.sv */
`timescale 1ns/1ps

module fpu_issue_top (
  input  logic                clock,
  input  logic                reset,
  input  logic                in_valid_i,
  input  fpu_pkg::fpu_req_t   in_req_i,
  output logic                in_ready_o,
  output logic                out_valid_o,
  output fpu_pkg::fpu_resp_t  out_resp_o,
  input  logic                out_ready_i,
  input  fpu_pkg::csr_req_t   csr_req_i,
  output fpu_pkg::csr_resp_t  csr_resp_o
);

  fpu_pkg::fpu_dec_t     dec;
  fpu_pkg::fpu_rf_rd_t   rf_rd;
  fpu_pkg::fpu_rf_data_t rf_data;
  fpu_pkg::fpu_rf_data_t opnd;
  fpu_pkg::fpu_wb_t      ex_fwd;
  fpu_pkg::fpu_wb_t      wb;
  fpu_pkg::fpu_resp_t    exec_resp;
  fpu_pkg::fpu_resp_t    ex_q;
  logic                  ex_valid;
  logic                  take_in;
  logic                  take_out;

  assign in_ready_o = !ex_valid || out_ready_i;
  assign take_in    = in_valid_i && in_ready_o;
  assign take_out   = ex_valid && out_ready_i;

  assign out_valid_o = ex_valid;
  assign out_resp_o  = ex_q;

  assign rf_rd.raddr1 = dec.rs1;
  assign rf_rd.raddr2 = dec.rs2;
  assign rf_rd.raddr3 = dec.rs3;

  // Pending fp result in the execute register.
  assign ex_fwd.wren  = ex_valid && ex_q.fwren;
  assign ex_fwd.waddr = ex_q.rd;
  assign ex_fwd.wdata = ex_q.result;

  assign wb.wren  = take_out && ex_q.fwren; // Commit on acceptance.
  assign wb.waddr = ex_q.rd;
  assign wb.wdata = ex_q.result;

  always_ff @(posedge clock) begin
    if (!reset) begin
      ex_valid <= 1'b0;
    end else if (take_in) begin
      ex_valid <= 1'b1;
    end else if (take_out) begin
      ex_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (take_in) begin
      ex_q <= exec_resp;
    end
  end

  fpu_decode u_decode (
    .instr_i (in_req_i.instr),
    .dec_o   (dec)
  );

  fpu_regfile u_regfile (
    .clock  (clock),
    .rd_i   (rf_rd),
    .wr_i   (wb),
    .data_o (rf_data)
  );

  fpu_forward u_forward (
    .dec_i  (dec),
    .rf_i   (rf_data),
    .ex_i   (ex_fwd),
    .opnd_o (opnd)
  );

  fpu_exec u_exec (
    .dec_i   (dec),
    .opnd_i  (opnd),
    .xopnd_i (in_req_i.opnd),
    .resp_o  (exec_resp)
  );

  fpu_csr u_csr (
    .clock       (clock),
    .reset       (reset),
    .req_i       (csr_req_i),
    .accrue_i    (ex_q.fflags),
    .accrue_en_i (take_out),
    .resp_o      (csr_resp_o)
  );

endmodule

/* hw/fpu_pkg.sv */
`include "fpu_config.svh"

package fpu_pkg;

  typedef enum logic [6:0] {
    OP_FP     = 7'b1010011,
    OP_FLOAD  = 7'b0000111,
    OP_FSTORE = 7'b0100111,
    OP_FMADD  = 7'b1000011,
    OP_FMSUB  = 7'b1000111,
    OP_FNMSUB = 7'b1001011,
    OP_FNMADD = 7'b1001111
  } opcode_e;

  // Upper five bits of funct7.
  typedef enum logic [4:0] {
    F_ADD     = 5'b00000,
    F_SUB     = 5'b00001,
    F_MUL     = 5'b00010,
    F_DIV     = 5'b00011,
    F_SGNJ    = 5'b00100,
    F_MINMAX  = 5'b00101,
    F_SQRT    = 5'b01011,
    F_CMP     = 5'b10100,
    F_CVT_W_S = 5'b11000,
    F_CVT_S_W = 5'b11010,
    F_MV_X    = 5'b11100, // Also fclass.
    F_MV_W    = 5'b11110
  } funct5_e;

  typedef enum logic [3:0] {
    OP_NONE,
    OP_SGNJ,
    OP_SGNJN,
    OP_SGNJX,
    OP_MIN,
    OP_MAX,
    OP_FEQ,
    OP_FLT,
    OP_FLE,
    OP_CLASS,
    OP_MV_X,
    OP_MV_W
  } fp_op_e;

  typedef enum logic [11:0] {
    CSR_FFLAGS = 12'h001,
    CSR_FRM    = 12'h002,
    CSR_FCSR   = 12'h003
  } csr_addr_e;

  typedef struct packed {
    logic [31:0]          instr;
    logic [`FPU_XLEN-1:0] opnd;
  } fpu_req_t;

  typedef struct packed {
    fp_op_e                  op;
    logic [`FPU_RADDR_W-1:0] rd;
    logic [`FPU_RADDR_W-1:0] rs1;
    logic [`FPU_RADDR_W-1:0] rs2;
    logic [`FPU_RADDR_W-1:0] rs3;
    logic                    frden1;
    logic                    frden2;
    logic                    frden3;
    logic                    fwren;
    logic                    xwren;
    logic                    illegal;
  } fpu_dec_t;

  typedef struct packed {
    logic [`FPU_RADDR_W-1:0] raddr1;
    logic [`FPU_RADDR_W-1:0] raddr2;
    logic [`FPU_RADDR_W-1:0] raddr3;
  } fpu_rf_rd_t;

  typedef struct packed {
    logic [`FPU_FLEN-1:0] data1;
    logic [`FPU_FLEN-1:0] data2;
    logic [`FPU_FLEN-1:0] data3;
  } fpu_rf_data_t;

  typedef struct packed {
    logic                    wren;
    logic [`FPU_RADDR_W-1:0] waddr;
    logic [`FPU_FLEN-1:0]    wdata;
  } fpu_wb_t;

  typedef struct packed {
    logic                    illegal;
    logic                    xwren;
    logic                    fwren;
    logic [`FPU_RADDR_W-1:0] rd;
    logic [`FPU_FLEN-1:0]    result; // Integer result shares this field.
    logic [4:0]              fflags;
  } fpu_resp_t;

  typedef struct packed {
    logic                 rden;
    logic                 wren;
    csr_addr_e            addr;
    logic [`FPU_XLEN-1:0] wdata;
  } csr_req_t;

  typedef struct packed {
    logic [`FPU_XLEN-1:0] rdata;
    logic                 hit;
  } csr_resp_t;

endpackage

/* hw/fpu_regfile.sv */
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu_regfile (
  input  logic                  clock,
  input  fpu_pkg::fpu_rf_rd_t   rd_i,
  input  fpu_pkg::fpu_wb_t      wr_i,
  output fpu_pkg::fpu_rf_data_t data_o
);

  logic [`FPU_FLEN-1:0] regs [`FPU_NREGS];

  always_ff @(posedge clock) begin
    if (wr_i.wren) begin
      regs[wr_i.waddr] <= wr_i.wdata;
    end
  end

  // Asynchronous reads.
  assign data_o.data1 = regs[rd_i.raddr1];
  assign data_o.data2 = regs[rd_i.raddr2];
  assign data_o.data3 = regs[rd_i.raddr3];

endmodule

/* include/fpu_config.svh */
`ifndef FPU_CONFIG_SVH
`define FPU_CONFIG_SVH

// Single precision only.
`define FPU_FLEN 32

`define FPU_XLEN 32

// Register file size and address width.
`define FPU_NREGS 32
`define FPU_RADDR_W 5

`endif

/* tests/fpu_checker.sv */
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu_checker (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 in_valid_i,
  input  logic                 in_ready_i,
  input  fpu_pkg::fpu_req_t    in_req_i,
  input  logic                 out_valid_i,
  input  logic                 out_ready_i,
  input  fpu_pkg::fpu_resp_t   out_resp_i,
  input  fpu_pkg::csr_req_t    csr_req_i,
  input  fpu_pkg::csr_resp_t   csr_resp_i,
  input  logic [`FPU_XLEN-1:0] csr_exp_i,
  output int                   error_count_o,
  output int                   check_count_o,
  output int                   pending_o
);

  logic [`FPU_FLEN-1:0] fregs [`FPU_NREGS];
  fpu_pkg::fpu_resp_t   expect_q [$];
  fpu_pkg::fpu_resp_t   expected;
  fpu_pkg::fpu_resp_t   held_resp;
  logic                 held;
  logic                 busy; // Execute register occupied.
  logic [4:0]           fflags_model;
  logic [2:0]           frm_model;
  logic [31:0]          csr_model;
  int                   resp_num = 0;
  int                   errors = 0;
  int                   checks = 0;
  int                   pending = 0;

  assign error_count_o = errors;
  assign check_count_o = checks;
  assign pending_o     = pending;

  function automatic logic is_nan(input logic [31:0] x);
    return x[30:23] == 8'hFF && x[22:0] != 0;
  endfunction

  function automatic logic is_snan(input logic [31:0] x);
    return is_nan(x) && !x[22];
  endfunction

  function automatic logic is_zero(input logic [31:0] x);
    return x[30:0] == 0;
  endfunction

  // Maps non-NaN values onto unsigned order, -0 just below +0.
  function automatic logic [31:0] order_key(input logic [31:0] x);
    return x[31] ? ~x : {1'b1, x[30:0]};
  endfunction

  function automatic logic [9:0] class_of(input logic [31:0] x);
    int pos;
    if (x[30:23] == 8'hFF) pos = (x[22:0] == 0) ? (x[31] ? 0 : 7) : (x[22] ? 9 : 8);
    else if (x[30:23] == 0) pos = (x[22:0] == 0) ? (x[31] ? 3 : 4) : (x[31] ? 2 : 5);
    else pos = x[31] ? 1 : 6;
    return 10'b1 << pos;
  endfunction

  function automatic fpu_pkg::fpu_resp_t predict(input logic [31:0] instr,
                                                 input logic [31:0] xop);
    fpu_pkg::fpu_resp_t r;
    logic [31:0]        a;
    logic [31:0]        b;
    logic [4:0]         f5;
    logic               unord;
    logic               lt;
    logic               eq;
    a     = fregs[instr[19:15]];
    b     = fregs[instr[24:20]];
    f5    = instr[31:27];
    unord = is_nan(a) || is_nan(b);
    lt    = !unord && order_key(a) < order_key(b) && !(is_zero(a) && is_zero(b));
    eq    = !unord && (a == b || (is_zero(a) && is_zero(b)));
    r         = '0;
    r.rd      = instr[11:7];
    r.illegal = 1'b1;
    if (instr[6:0] == 7'h53 && instr[26:25] == 2'b00) begin
      r.illegal = 1'b0;
      case ({f5, instr[14:12]})
        8'b00100_000: r.result = {b[31], a[30:0]};
        8'b00100_001: r.result = {!b[31], a[30:0]};
        8'b00100_010: r.result = {a[31] ^ b[31], a[30:0]};
        8'b00101_000, 8'b00101_001: begin
          r.fflags[4] = is_snan(a) || is_snan(b);
          if (is_nan(a) && is_nan(b)) r.result = 32'h7FC0_0000;
          else if (is_nan(a)) r.result = b;
          else if (is_nan(b)) r.result = a;
          else if ((order_key(a) < order_key(b)) == (instr[14:12] == 3'd0)) r.result = a;
          else r.result = b;
        end
        8'b10100_010: begin
          r.fflags[4] = is_snan(a) || is_snan(b);
          r.result    = {31'b0, eq};
        end
        8'b10100_001: begin
          r.fflags[4] = unord;
          r.result    = {31'b0, lt};
        end
        8'b10100_000: begin
          r.fflags[4] = unord;
          r.result    = {31'b0, lt | eq};
        end
        8'b11100_000: r.result = a;
        8'b11100_001: r.result = {22'b0, class_of(a)};
        8'b11110_000: r.result = xop;
        default:      r.illegal = 1'b1;
      endcase
    end
    r.fwren = !r.illegal && (f5 == 5'b00100 || f5 == 5'b00101 || f5 == 5'b11110);
    r.xwren = !r.illegal && !r.fwren;
    return r;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  always @(posedge clock) begin
    if (!reset) begin
      fflags_model = '0;
      frm_model    = '0;
      held         = 1'b0;
      busy         = 1'b0;
    end else begin
      if (csr_req_i.rden) begin
        case (csr_req_i.addr)
          fpu_pkg::CSR_FFLAGS: csr_model = {27'b0, fflags_model};
          fpu_pkg::CSR_FRM:    csr_model = {29'b0, frm_model};
          default:             csr_model = {24'b0, frm_model, fflags_model};
        endcase
        check_value("CSR read data", csr_resp_i.rdata, csr_model);
        check_value("CSR read against stimulus", csr_resp_i.rdata, csr_exp_i);
        check_value("CSR hit", {31'b0, csr_resp_i.hit}, 32'd1);
      end

      // One-cycle latency and ready whenever the stage is empty or drains.
      check_value("output valid", {31'b0, out_valid_i}, {31'b0, busy});
      check_value("input ready", {31'b0, in_ready_i}, {31'b0, (!busy || out_ready_i)});

      if (held) begin
        if (out_resp_i !== held_resp) begin
          errors++;
          $display("Error at time %0t: response changed while stalled", $time);
        end
      end
      held      = out_valid_i && !out_ready_i;
      held_resp = out_resp_i;

      if (out_valid_i && out_ready_i) begin
        if (expect_q.size() == 0) begin
          errors++;
          $display("Error at time %0t: response with no accepted instruction", $time);
        end else begin
          expected = expect_q.pop_front();
          check_value($sformatf("response %0d result", resp_num),
                      out_resp_i.result, expected.result);
          check_value($sformatf("response %0d fflags", resp_num),
                      {27'b0, out_resp_i.fflags}, {27'b0, expected.fflags});
          check_value($sformatf("response %0d rd", resp_num),
                      {27'b0, out_resp_i.rd}, {27'b0, expected.rd});
          check_value($sformatf("response %0d illegal/xwren/fwren", resp_num),
                      {29'b0, out_resp_i.illegal, out_resp_i.xwren, out_resp_i.fwren},
                      {29'b0, expected.illegal, expected.xwren, expected.fwren});
          fflags_model = fflags_model | expected.fflags;
          resp_num++;
        end
      end
      if (busy && out_ready_i) begin
        busy = 1'b0;
      end

      // Software write lands after accrual on the same edge.
      if (csr_req_i.wren) begin
        case (csr_req_i.addr)
          fpu_pkg::CSR_FFLAGS: fflags_model = csr_req_i.wdata[4:0];
          fpu_pkg::CSR_FRM:    frm_model = csr_req_i.wdata[2:0];
          fpu_pkg::CSR_FCSR: begin
            fflags_model = csr_req_i.wdata[4:0];
            frm_model    = csr_req_i.wdata[7:5];
          end
          default: ;
        endcase
      end

      if (in_valid_i && in_ready_i) begin
        expected = predict(in_req_i.instr, in_req_i.opnd);
        expect_q.push_back(expected);
        if (expected.fwren) begin
          fregs[expected.rd] = expected.result; // Program order.
        end
        busy = 1'b1;
      end
      pending = expect_q.size();
    end
  end

endmodule

/* tests/fpu_stimulus.txt */
// kind_instr_operand_expected, all hex. kind 00 instruction, 01 CSR read, 02 CSR write.
// For CSR lines the instr column holds the CSR address; expected is used by reads only.
00_F00000D3_3F800000_00000000
00_E0008553_00000000_00000000
00_F0000153_C0000000_00000000
00_202081D3_00000000_00000000
00_20219253_00000000_00000000
00_2021A2D3_00000000_00000000
00_F0000353_80000000_00000000
00_F00002D3_00000000_00000000
00_285303D3_00000000_00000000
00_28531453_00000000_00000000
00_A05325D3_00000000_00000000
00_F00004D3_7FC00000_00000000
00_F0000553_7F800001_00000000
00_281485D3_00000000_00000000
01_00000001_00000000_00000000
00_A0152653_00000000_00000000
01_00000001_00000000_00000010
02_00000002_00000003_00000000
01_00000003_00000000_00000070
02_00000001_00000000_00000000
00_A01496D3_00000000_00000000
00_A0808753_00000000_00000000
00_E00317D3_00000000_00000000
00_E0051853_00000000_00000000
00_28251653_00000000_00000000
00_E00608D3_00000000_00000000
// fadd, flw and an unknown funct5.
00_002086D3_00000000_00000000
00_0000A707_00000000_00000000
00_781082D3_00000000_00000000
00_E0028953_00000000_00000000
01_00000001_00000000_00000010
01_00000002_00000000_00000003
01_00000003_00000000_00000070
02_00000001_00000000_00000000
01_00000003_00000000_00000060

/* tests/fpu_tb.sv */
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu_tb;

  localparam int clk_period      = 100;
  localparam int max_lines       = 64;
  localparam int cycles_per_line = 40;

  logic                 clock;
  logic                 reset;
  logic                 in_valid;
  fpu_pkg::fpu_req_t    in_req;
  logic                 in_ready;
  logic                 out_valid;
  fpu_pkg::fpu_resp_t   out_resp;
  logic                 out_ready;
  fpu_pkg::csr_req_t    csr_req;
  fpu_pkg::csr_resp_t   csr_resp;
  logic [`FPU_XLEN-1:0] csr_exp;
  logic [103:0]         lines [max_lines];
  int                   n_lines;
  int                   idx;
  int                   bad_lines;
  logic                 loaded;
  logic [31:0]          rnd_state;
  int                   error_count;
  int                   check_count;
  int                   pending;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Offer one instruction and hold it until the DUT takes it.
  task automatic send_instr(input logic [31:0] instr, input logic [31:0] opnd);
    @(negedge clock);
    in_valid     = 1'b1;
    in_req.instr = instr;
    in_req.opnd  = opnd;
    @(posedge clock);
    while (!in_ready) begin
      @(posedge clock);
    end
  endtask

  task automatic drain_responses();
    @(negedge clock);
    in_valid = 1'b0;
    while (out_valid) begin
      @(negedge clock);
    end
  endtask

  // Single-cycle access once the pipeline is empty, so flags are settled.
  task automatic csr_access(input logic rd, input logic wr, input logic [11:0] addr,
                            input logic [31:0] wdata, input logic [31:0] expected);
    drain_responses();
    csr_req.rden  = rd;
    csr_req.wren  = wr;
    csr_req.addr  = fpu_pkg::csr_addr_e'(addr);
    csr_req.wdata = wdata;
    csr_exp       = expected;
    @(negedge clock);
    csr_req = '0;
  endtask

  initial begin
    clock = 1'b0;
    forever #(clk_period / 2) clock = ~clock;
  end

  // Random back-pressure, about three cycles in four ready.
  initial begin
    out_ready = 1'b0;
    rnd_state = 32'd73;
    forever begin
      @(negedge clock);
      rnd_state = xorshift32(rnd_state);
      out_ready = rnd_state[0] | rnd_state[1];
    end
  end

  initial begin
    reset     = 1'b0;
    in_valid  = 1'b0;
    in_req    = '0;
    csr_req   = '0;
    csr_exp   = '0;
    loaded    = 1'b0;
    n_lines   = 0;
    bad_lines = 0;
    $readmemh("tests/fpu_stimulus.txt", lines);
    while (n_lines < max_lines && !$isunknown(lines[n_lines][103:96])) begin
      n_lines++;
    end
    loaded = 1'b1;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;

    for (idx = 0; idx < n_lines; idx++) begin
      case (lines[idx][103:96])
        8'h00: send_instr(lines[idx][95:64], lines[idx][63:32]);
        8'h01: csr_access(1'b1, 1'b0, lines[idx][75:64], '0, lines[idx][31:0]);
        8'h02: csr_access(1'b0, 1'b1, lines[idx][75:64], lines[idx][63:32], '0);
        default: begin
          bad_lines++;
          $display("Stimulus line %0d has an unknown kind %h", idx, lines[idx][103:96]);
        end
      endcase
    end
    drain_responses();
    repeat (2) @(negedge clock);

    $display("Summary: %0d checks, %0d errors, %0d responses missing, %0d bad lines",
             check_count, error_count, pending, bad_lines);
    if (error_count == 0 && pending == 0 && bad_lines == 0 && check_count > 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog scaled to the stimulus length.
  initial begin
    wait (loaded);
    #((n_lines + 4) * cycles_per_line * clk_period);
    $display("Timeout: the run did not finish within %0d clock cycles",
             (n_lines + 4) * cycles_per_line);
    $display("tests failed");
    $finish;
  end

  fpu_issue_top UUT (
    .clock       (clock),
    .reset       (reset),
    .in_valid_i  (in_valid),
    .in_req_i    (in_req),
    .in_ready_o  (in_ready),
    .out_valid_o (out_valid),
    .out_resp_o  (out_resp),
    .out_ready_i (out_ready),
    .csr_req_i   (csr_req),
    .csr_resp_o  (csr_resp)
  );

  fpu_checker u_checker (
    .clock         (clock),
    .reset         (reset),
    .in_valid_i    (in_valid),
    .in_ready_i    (in_ready),
    .in_req_i      (in_req),
    .out_valid_i   (out_valid),
    .out_ready_i   (out_ready),
    .out_resp_i    (out_resp),
    .csr_req_i     (csr_req),
    .csr_resp_i    (csr_resp),
    .csr_exp_i     (csr_exp),
    .error_count_o (error_count),
    .check_count_o (check_count),
    .pending_o     (pending)
  );

endmodule
